/* include/udp_echo_params.svh */
// udp echo parameters: field widths, register reset values and reply ttl
`ifndef UDP_ECHO_PARAMS_SVH
`define UDP_ECHO_PARAMS_SVH

// header and payload field widths
`define UDP_ECHO_IP_W   32
`define UDP_ECHO_PORT_W 16
`define UDP_ECHO_LEN_W  16
`define UDP_ECHO_DATA_W 8

// ttl placed in every reply header
`define UDP_ECHO_TTL 8'd64

// config register values after reset
// 192.168.1.128
`define UDP_ECHO_LOCAL_IP_RST 32'hc0a8_0180
`define UDP_ECHO_PORT_RST     16'd1234

`endif

/* logic/udp_echo_cfg.sv */
// udp echo config registers: local ip, listening port and echo enable
`timescale 1ns/10ps
`default_nettype none

`include "udp_echo_params.svh"

module udp_echo_cfg (
    input  logic                   clk,
    input  logic                   rst,

    // register write port, always accepted
    input  logic                   cfg_wr_en,
    input  udp_echo_pkg::cfg_reg_e cfg_sel,
    input  logic [31:0]            cfg_wr_data,

    output udp_echo_pkg::ip_addr_t  local_ip,
    output udp_echo_pkg::udp_port_t listen_port,
    output logic                    echo_en
);

    import udp_echo_pkg::*;

    // written value is visible from the next edge on
    always_ff @(posedge clk) begin
        if (rst) begin
            local_ip    <= `UDP_ECHO_LOCAL_IP_RST;
            listen_port <= `UDP_ECHO_PORT_RST;
            echo_en     <= 1'b1;
        end else if (cfg_wr_en) begin
            case (cfg_sel)
                CFG_LOCAL_IP: begin
                    local_ip <= cfg_wr_data[`UDP_ECHO_IP_W-1:0];
                end
                CFG_LISTEN_PORT: begin
                    listen_port <= cfg_wr_data[`UDP_ECHO_PORT_W-1:0];
                end
                CFG_CONTROL: begin
                    echo_en <= cfg_wr_data[0];
                end
                default: begin
                    // unmapped select, write ignored
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/udp_echo_pkg.sv */
// udp echo package: address, port, length and byte types plus fsm and register enums
`default_nettype none

`include "udp_echo_params.svh"

package udp_echo_pkg;

    typedef logic [`UDP_ECHO_IP_W-1:0]   ip_addr_t;
    typedef logic [`UDP_ECHO_PORT_W-1:0] udp_port_t;
    typedef logic [`UDP_ECHO_LEN_W-1:0]  udp_len_t;
    typedef logic [`UDP_ECHO_DATA_W-1:0] data_byte_t;

    // per-frame routing decision of the port filter
    typedef enum logic [1:0] {
        FILTER_IDLE    = 2'd0,
        FILTER_ACCEPT  = 2'd1,
        FILTER_DISCARD = 2'd2
    } filter_state_e;

    // config register select
    // bit 0 of the CFG_CONTROL word is echo enable
    typedef enum logic [1:0] {
        CFG_LOCAL_IP    = 2'd0,
        CFG_LISTEN_PORT = 2'd1,
        CFG_CONTROL     = 2'd2
    } cfg_reg_e;

endpackage

`default_nettype wire

/* logic/udp_echo_top.sv */
// udp echo top: config registers, port filter, reply header builder and led capture
`timescale 1ns/10ps
`default_nettype none

module udp_echo_top (
    input  logic                     clk,
    input  logic                     rst,

    // received udp header
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t   rx_src_ip,
    input  udp_echo_pkg::udp_port_t  rx_src_port,
    input  udp_echo_pkg::udp_port_t  rx_dst_port,
    input  udp_echo_pkg::udp_len_t   rx_length,

    // received udp payload
    input  udp_echo_pkg::data_byte_t rx_data,
    input  logic                     rx_valid,
    output logic                     rx_ready,
    input  logic                     rx_last,
    input  logic                     rx_user,

    // application receive stream
    output udp_echo_pkg::data_byte_t app_rx_data,
    output logic                     app_rx_valid,
    input  logic                     app_rx_ready,
    output logic                     app_rx_last,
    output logic                     app_rx_user,

    // application transmit stream
    input  udp_echo_pkg::data_byte_t app_tx_data,
    input  logic                     app_tx_valid,
    output logic                     app_tx_ready,
    input  logic                     app_tx_last,
    input  logic                     app_tx_user,

    // transmit udp header
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t   tx_src_ip,
    output udp_echo_pkg::ip_addr_t   tx_dst_ip,
    output udp_echo_pkg::udp_port_t  tx_src_port,
    output udp_echo_pkg::udp_port_t  tx_dst_port,
    output udp_echo_pkg::udp_len_t   tx_length,
    output logic [7:0]               tx_ttl,

    // transmit udp payload
    output udp_echo_pkg::data_byte_t tx_data,
    output logic                     tx_valid,
    input  logic                     tx_ready,
    output logic                     tx_last,
    output logic                     tx_user,

    // config write
    input  logic                     cfg_wr_en,
    input  udp_echo_pkg::cfg_reg_e   cfg_sel,
    input  logic [31:0]              cfg_wr_data,

    output udp_echo_pkg::data_byte_t led
);

    import udp_echo_pkg::*;

    ip_addr_t  local_ip;
    udp_port_t listen_port;
    logic      echo_en;

    // filter to reply builder
    logic      reply_valid;
    logic      reply_ready;
    ip_addr_t  reply_src_ip;
    udp_port_t reply_src_port;
    udp_port_t reply_dst_port;
    udp_len_t  reply_length;

    // transmit payload passes straight through
    assign tx_data      = app_tx_data;
    assign tx_valid     = app_tx_valid;
    assign app_tx_ready = tx_ready;
    assign tx_last      = app_tx_last;
    assign tx_user      = app_tx_user;

    udp_echo_cfg u_cfg (
        .clk         (clk),
        .rst         (rst),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_sel     (cfg_sel),
        .cfg_wr_data (cfg_wr_data),
        .local_ip    (local_ip),
        .listen_port (listen_port),
        .echo_en     (echo_en)
    );

    udp_port_filter u_filter (
        .clk            (clk),
        .rst            (rst),
        .listen_port    (listen_port),
        .echo_en        (echo_en),
        .rx_hdr_valid   (rx_hdr_valid),
        .rx_hdr_ready   (rx_hdr_ready),
        .rx_src_ip      (rx_src_ip),
        .rx_src_port    (rx_src_port),
        .rx_dst_port    (rx_dst_port),
        .rx_length      (rx_length),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .rx_last        (rx_last),
        .rx_user        (rx_user),
        .app_rx_data    (app_rx_data),
        .app_rx_valid   (app_rx_valid),
        .app_rx_ready   (app_rx_ready),
        .app_rx_last    (app_rx_last),
        .app_rx_user    (app_rx_user),
        .reply_valid    (reply_valid),
        .reply_ready    (reply_ready),
        .reply_src_ip   (reply_src_ip),
        .reply_src_port (reply_src_port),
        .reply_dst_port (reply_dst_port),
        .reply_length   (reply_length)
    );

    udp_reply_hdr u_reply (
        .clk            (clk),
        .rst            (rst),
        .local_ip       (local_ip),
        .reply_valid    (reply_valid),
        .reply_ready    (reply_ready),
        .reply_src_ip   (reply_src_ip),
        .reply_src_port (reply_src_port),
        .reply_dst_port (reply_dst_port),
        .reply_length   (reply_length),
        .tx_hdr_valid   (tx_hdr_valid),
        .tx_hdr_ready   (tx_hdr_ready),
        .tx_src_ip      (tx_src_ip),
        .tx_dst_ip      (tx_dst_ip),
        .tx_src_port    (tx_src_port),
        .tx_dst_port    (tx_dst_port),
        .tx_length      (tx_length),
        .tx_ttl         (tx_ttl)
    );

    udp_led_capture u_led (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (app_tx_data),
        .tx_valid (app_tx_valid),
        .tx_ready (tx_ready),
        .tx_last  (app_tx_last),
        .led      (led)
    );

endmodule

`default_nettype wire

/* logic/udp_led_capture.sv */
// led capture: shows the first transmitted payload byte of each frame on the leds
`timescale 1ns/10ps
`default_nettype none

module udp_led_capture (
    input  logic                     clk,
    input  logic                     rst,

    // transmit payload, observed only
    input  udp_echo_pkg::data_byte_t tx_data,
    input  logic                     tx_valid,
    input  logic                     tx_ready,
    input  logic                     tx_last,

    output udp_echo_pkg::data_byte_t led
);

    logic tx_fire;
    logic first_q;

    assign tx_fire = tx_valid && tx_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            first_q <= 1'b1;
            led     <= '0;
        end else if (tx_fire) begin
            if (first_q) begin
                led <= tx_data;
            end
            // next transfer opens a new frame after a last
            first_q <= tx_last;
        end
    end

endmodule

`default_nettype wire

/* logic/udp_port_filter.sv */
// udp port filter: matches the destination port and routes each payload to the app or drops it
`timescale 1ns/10ps
`default_nettype none

module udp_port_filter (
    input  logic                     clk,
    input  logic                     rst,

    // config
    input  udp_echo_pkg::udp_port_t  listen_port,
    input  logic                     echo_en,

    // received udp header
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t   rx_src_ip,
    input  udp_echo_pkg::udp_port_t  rx_src_port,
    input  udp_echo_pkg::udp_port_t  rx_dst_port,
    input  udp_echo_pkg::udp_len_t   rx_length,

    // received payload
    input  udp_echo_pkg::data_byte_t rx_data,
    input  logic                     rx_valid,
    output logic                     rx_ready,
    input  logic                     rx_last,
    input  logic                     rx_user,

    // payload towards the application
    output udp_echo_pkg::data_byte_t app_rx_data,
    output logic                     app_rx_valid,
    input  logic                     app_rx_ready,
    output logic                     app_rx_last,
    output logic                     app_rx_user,

    // received header fields for the reply builder
    output logic                     reply_valid,
    input  logic                     reply_ready,
    output udp_echo_pkg::ip_addr_t   reply_src_ip,
    output udp_echo_pkg::udp_port_t  reply_src_port,
    output udp_echo_pkg::udp_port_t  reply_dst_port,
    output udp_echo_pkg::udp_len_t   reply_length
);

    import udp_echo_pkg::*;

    filter_state_e state;
    filter_state_e state_next;
    logic          port_match;

    // frame is echoed only when enabled and addressed to our port
    assign port_match = echo_en && (rx_dst_port == listen_port);

    // header fields go out unchanged, the builder does the swap
    assign reply_src_ip   = rx_src_ip;
    assign reply_src_port = rx_src_port;
    assign reply_dst_port = rx_dst_port;
    assign reply_length   = rx_length;

    // payload sideband always follows the input
    assign app_rx_data = rx_data;
    assign app_rx_last = rx_last;
    assign app_rx_user = rx_user;

    always_comb begin
        state_next   = state;
        rx_hdr_ready = 1'b0;
        reply_valid  = 1'b0;
        rx_ready     = 1'b0;
        app_rx_valid = 1'b0;

        case (state)
            FILTER_IDLE: begin
                // a match has to wait for room in the reply stage
                rx_hdr_ready = !port_match || reply_ready;
                reply_valid  = rx_hdr_valid && port_match && reply_ready;
                if (rx_hdr_valid && (!port_match || reply_ready)) begin
                    state_next = port_match ? FILTER_ACCEPT : FILTER_DISCARD;
                end
            end
            FILTER_ACCEPT: begin
                // zero latency pass to the application
                app_rx_valid = rx_valid;
                rx_ready     = app_rx_ready;
                if (rx_valid && app_rx_ready && rx_last) begin
                    state_next = FILTER_IDLE;
                end
            end
            FILTER_DISCARD: begin
                // sink every byte until the end of frame
                rx_ready = 1'b1;
                if (rx_valid && rx_last) begin
                    state_next = FILTER_IDLE;
                end
            end
            default: begin
                state_next = FILTER_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILTER_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

/* logic/udp_reply_hdr.sv */
// udp reply header builder: one-entry stage holding the swapped reply header
`timescale 1ns/10ps
`default_nettype none

`include "udp_echo_params.svh"

module udp_reply_hdr (
    input  logic                    clk,
    input  logic                    rst,

    input  udp_echo_pkg::ip_addr_t  local_ip,

    // received header fields from the filter
    input  logic                    reply_valid,
    output logic                    reply_ready,
    input  udp_echo_pkg::ip_addr_t  reply_src_ip,
    input  udp_echo_pkg::udp_port_t reply_src_port,
    input  udp_echo_pkg::udp_port_t reply_dst_port,
    input  udp_echo_pkg::udp_len_t  reply_length,

    // outgoing reply header
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t  tx_src_ip,
    output udp_echo_pkg::ip_addr_t  tx_dst_ip,
    output udp_echo_pkg::udp_port_t tx_src_port,
    output udp_echo_pkg::udp_port_t tx_dst_port,
    output udp_echo_pkg::udp_len_t  tx_length,
    output logic [7:0]              tx_ttl
);

    logic load;

    // room when empty or when the held header leaves this cycle
    assign reply_ready = !tx_hdr_valid || tx_hdr_ready;
    assign load        = reply_valid && reply_ready;

    assign tx_ttl = `UDP_ECHO_TTL;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
        end else if (load) begin
            tx_hdr_valid <= 1'b1;
        end else if (tx_hdr_ready) begin
            tx_hdr_valid <= 1'b0;
        end
    end

    // reply goes back to the sender from our address
    // local ip is sampled in the cycle the header is accepted
    always_ff @(posedge clk) begin
        if (load) begin
            tx_src_ip   <= local_ip;
            tx_dst_ip   <= reply_src_ip;
            tx_src_port <= reply_dst_port;
            tx_dst_port <= reply_src_port;
            tx_length   <= reply_length;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the udp echo testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module udp_echo_tb -f udp_echo.f
./obj_dir/Vudp_echo_tb

/* tb/udp_echo_golden.txt */
# C sel data | F src_ip src_port dst_port length match local_ip user count bytes
# T user count bytes led | H holds tx_hdr_ready low | E checks the held header stalled
F c0a80105 c350 04d2 000c 1 c0a80180 0 4 de ad be ef
F c0a80105 c351 04d3 000b 0 c0a80180 0 3 11 22 33
F 0a000001 1f90 04d2 0009 1 c0a80180 1 1 5a
T 0 4 a1 b2 c3 d4 a1
# listening port moves to 5000
C 1 00001388
F c0a80105 c350 04d2 000a 0 c0a80180 0 2 01 02
F c0a80105 c350 1388 000a 1 c0a80180 0 2 03 04
# new local ip 10.0.0.10
C 0 0a00000a
F ac100001 0035 1388 000d 1 0a00000a 1 5 10 20 30 40 50
# two matching frames back to back with the reply held
H
F c0a80107 1000 1388 000a 1 0a00000a 0 2 aa bb
F c0a80108 1001 1388 000b 1 0a00000a 1 3 cc dd ee
E
T 1 1 7e 7e
# echo disabled
C 2 00000000
F c0a80105 c350 1388 000a 0 0a00000a 0 2 05 06
F c0a80105 c350 04d2 000a 0 0a00000a 0 2 07 08
# echo enabled again
C 2 00000001
F c0a80109 2000 1388 000c 1 0a00000a 0 4 01 23 45 67
T 0 6 00 ff 10 20 30 40 00
F c0a8010a 2001 1388 0010 1 0a00000a 1 8 80 81 82 83 84 85 86 87
T 1 3 5c 6d 7e 5c

/* tb/udp_echo_tb.sv */
// udp echo testbench replaying golden records against replies, app payload, tx bytes and leds
`timescale 1ns/10ps
`default_nettype none

module udp_echo_tb;

    import udp_echo_pkg::*;

    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
    } reply_t;

    typedef struct packed {
        data_byte_t data;
        logic       last;
        logic       user;
    } beat_t;

    logic       clk;
    logic       rst;
    logic       rx_hdr_valid;
    logic       rx_hdr_ready;
    ip_addr_t   rx_src_ip;
    udp_port_t  rx_src_port;
    udp_port_t  rx_dst_port;
    udp_len_t   rx_length;
    data_byte_t rx_data;
    data_byte_t app_rx_data;
    data_byte_t app_tx_data;
    data_byte_t tx_data;
    data_byte_t led;
    logic       rx_valid;
    logic       rx_ready;
    logic       rx_last;
    logic       rx_user;
    logic       app_rx_valid;
    logic       app_rx_ready;
    logic       app_rx_last;
    logic       app_rx_user;
    logic       app_tx_valid;
    logic       app_tx_ready;
    logic       app_tx_last;
    logic       app_tx_user;
    logic       tx_hdr_valid;
    logic       tx_hdr_ready;
    ip_addr_t   tx_src_ip;
    ip_addr_t   tx_dst_ip;
    udp_port_t  tx_src_port;
    udp_port_t  tx_dst_port;
    udp_len_t   tx_length;
    logic [7:0] tx_ttl;
    logic       tx_valid;
    logic       tx_ready;
    logic       tx_last;
    logic       tx_user;
    logic       cfg_wr_en;
    cfg_reg_e   cfg_sel;
    logic [31:0] cfg_wr_data;

    // reference model of the config registers
    ip_addr_t   model_ip;
    udp_port_t  model_port;
    logic       model_echo;

    reply_t     exp_hdr_q[$];
    beat_t      exp_app_q[$];
    beat_t      exp_tx_q[$];
    data_byte_t frame_bytes [0:255];
    logic [31:0] lfsr = 32'h5e6a;
    logic       hold_hdr;
    logic       cur_match;
    int         cycles = 0;
    int         limit = 200;

    udp_echo_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_ip(input string name, input ip_addr_t got, input ip_addr_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_port(input string name, input udp_port_t got, input udp_port_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_len(input string name, input udp_len_t got, input udp_len_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input data_byte_t got, input data_byte_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic read_payload(input int fd, input int n);
        int code;
        if (n < 1 || n > 256) begin
            stop_with_error("payload byte count in the golden file is out of range");
        end
        for (int i = 0; i < n; i++) begin
            code = $fscanf(fd, "%h", frame_bytes[i]);
            if (code != 1) begin
                stop_with_error("golden file ends inside a payload byte list");
            end
        end
    endtask

    task automatic send_header(input ip_addr_t sip, input udp_port_t sport,
                               input udp_port_t dport, input udp_len_t len, input logic match);
        int stall;
        stall = 0;
        @(negedge clk);
        rx_hdr_valid = 1'b1;
        rx_src_ip    = sip;
        rx_src_port  = sport;
        rx_dst_port  = dport;
        rx_length    = len;
        cur_match    = match;
        do begin
            @(posedge clk);
            if (!rx_hdr_ready) begin
                stall++;
            end
            // let the held reply go once the header has clearly stalled
            if (hold_hdr && stall >= 6) begin
                hold_hdr = 1'b0;
            end
        end while (!rx_hdr_ready);
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        cur_match    = 1'b0;
    endtask

    task automatic send_payload(input int n, input logic user);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            rx_valid = 1'b1;
            rx_data  = frame_bytes[i];
            rx_last  = (i == n - 1);
            rx_user  = (i == n - 1) && user;
            do @(posedge clk); while (!rx_ready);
        end
        @(negedge clk);
        rx_valid = 1'b0;
        rx_last  = 1'b0;
        rx_user  = 1'b0;
    endtask

    task automatic send_app_tx(input int n, input logic user);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            app_tx_valid = 1'b1;
            app_tx_data  = frame_bytes[i];
            app_tx_last  = (i == n - 1);
            app_tx_user  = (i == n - 1) && user;
            do @(posedge clk); while (!app_tx_ready);
        end
        @(negedge clk);
        app_tx_valid = 1'b0;
        app_tx_last  = 1'b0;
        app_tx_user  = 1'b0;
    endtask

    // random back-pressure on every sink
    initial begin
        app_rx_ready = 1'b0;
        tx_hdr_ready = 1'b0;
        tx_ready     = 1'b0;
        forever begin
            @(negedge clk);
            app_rx_ready = lfsr[0];
            lfsr = lfsr_step(lfsr);
            tx_ready = lfsr[0];
            lfsr = lfsr_step(lfsr);
            tx_hdr_ready = lfsr[0] && !hold_hdr;
            lfsr = lfsr_step(lfsr);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            stop_with_error($sformatf("timeout after %0d cycles, the DUT stopped responding",
                                      cycles));
        end
    end

    always @(posedge clk) begin
        reply_t r;
        beat_t  b;
        if (!rst) begin
            if (rx_hdr_valid && rx_hdr_ready && cur_match && tx_hdr_valid && !tx_hdr_ready) begin
                stop_with_error("matching header was accepted while the reply stage was full");
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    stop_with_error("tx header appeared without a matching frame");
                end else begin
                    r = exp_hdr_q.pop_front();
                    check_ip("tx_src_ip", tx_src_ip, r.src_ip);
                    check_ip("tx_dst_ip", tx_dst_ip, r.dst_ip);
                    check_port("tx_src_port", tx_src_port, r.src_port);
                    check_port("tx_dst_port", tx_dst_port, r.dst_port);
                    check_len("tx_length", tx_length, r.length);
                    check_byte("tx_ttl", tx_ttl, 8'd64);
                end
            end
            if (app_rx_valid && app_rx_ready) begin
                if (exp_app_q.size() == 0) begin
                    stop_with_error("app_rx byte appeared without a matching frame");
                end else begin
                    b = exp_app_q.pop_front();
                    check_byte("app_rx_data", app_rx_data, b.data);
                    check_bit("app_rx_last", app_rx_last, b.last);
                    check_bit("app_rx_user", app_rx_user, b.user);
                end
            end
            if (tx_valid && tx_ready) begin
                if (exp_tx_q.size() == 0) begin
                    stop_with_error("tx payload byte appeared without an app_tx frame");
                end else begin
                    b = exp_tx_q.pop_front();
                    check_byte("tx_data", tx_data, b.data);
                    check_bit("tx_last", tx_last, b.last);
                    check_bit("tx_user", tx_user, b.user);
                end
            end
        end
    end

    initial begin
        string      kind;
        int         fd;
        int         code;
        int         n;
        int         ch;
        logic [1:0] sel_raw;
        logic [31:0] wr_data;
        ip_addr_t   f_src_ip;
        ip_addr_t   g_local_ip;
        udp_port_t  f_src_port;
        udp_port_t  f_dst_port;
        udp_len_t   f_len;
        logic       g_match;
        logic       f_user;
        logic       exp_match;
        data_byte_t g_led;
        rst          = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_src_ip    = '0;
        rx_src_port  = '0;
        rx_dst_port  = '0;
        rx_length    = '0;
        rx_data      = '0;
        rx_valid     = 1'b0;
        rx_last      = 1'b0;
        rx_user      = 1'b0;
        app_tx_data  = '0;
        app_tx_valid = 1'b0;
        app_tx_last  = 1'b0;
        app_tx_user  = 1'b0;
        cfg_wr_en    = 1'b0;
        cfg_sel      = CFG_LOCAL_IP;
        cfg_wr_data  = '0;
        hold_hdr     = 1'b0;
        cur_match    = 1'b0;
        // register values after reset are 192.168.1.128 and port 1234
        model_ip     = 32'hc0a8_0180;
        model_port   = 16'd1234;
        model_echo   = 1'b1;
        fd = $fopen("tb/udp_echo_golden.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open the golden file tb/udp_echo_golden.txt");
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_bit("tx_hdr_valid", tx_hdr_valid, 1'b0);
        check_bit("app_rx_valid", app_rx_valid, 1'b0);
        check_bit("rx_ready", rx_ready, 1'b0);
        check_byte("led", led, 8'h00);

        while (1'b1) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                break;
            end
            if (kind == "#") begin
                do begin
                    ch = $fgetc(fd);
                end while (ch != 10 && ch != -1);
            end else if (kind == "C") begin
                code = $fscanf(fd, "%h %h", sel_raw, wr_data);
                if (code != 2) begin
                    stop_with_error("malformed config record in the golden file");
                end
                limit += 200;
                @(negedge clk);
                cfg_wr_en   = 1'b1;
                cfg_sel     = cfg_reg_e'(sel_raw);
                cfg_wr_data = wr_data;
                @(negedge clk);
                cfg_wr_en = 1'b0;
                case (cfg_reg_e'(sel_raw))
                    CFG_LOCAL_IP:    model_ip = wr_data;
                    CFG_LISTEN_PORT: model_port = wr_data[15:0];
                    CFG_CONTROL:     model_echo = wr_data[0];
                    default: begin
                        // unmapped select leaves the registers alone
                    end
                endcase
            end else if (kind == "F") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %d", f_src_ip, f_src_port,
                               f_dst_port, f_len, g_match, g_local_ip, f_user, n);
                if (code != 8) begin
                    stop_with_error("malformed frame record in the golden file");
                end
                read_payload(fd, n);
                limit += 200 + 16 * n;
                exp_match = model_echo && (f_dst_port == model_port);
                check_bit("golden match flag", g_match, exp_match);
                check_ip("golden local ip", g_local_ip, model_ip);
                if (exp_match) begin
                    // ports swapped so the reply goes back to the sender
                    exp_hdr_q.push_back('{src_ip: model_ip, dst_ip: f_src_ip,
                                          src_port: f_dst_port, dst_port: f_src_port,
                                          length: f_len});
                    for (int i = 0; i < n; i++) begin
                        exp_app_q.push_back('{data: frame_bytes[i], last: (i == n - 1),
                                              user: (i == n - 1) && f_user});
                    end
                end
                send_header(f_src_ip, f_src_port, f_dst_port, f_len, exp_match);
                send_payload(n, f_user);
            end else if (kind == "T") begin
                code = $fscanf(fd, "%h %d", f_user, n);
                if (code != 2) begin
                    stop_with_error("malformed app_tx record in the golden file");
                end
                read_payload(fd, n);
                code = $fscanf(fd, "%h", g_led);
                if (code != 1) begin
                    stop_with_error("app_tx record in the golden file has no led byte");
                end
                limit += 200 + 16 * n;
                check_byte("golden led", g_led, frame_bytes[0]);
                for (int i = 0; i < n; i++) begin
                    exp_tx_q.push_back('{data: frame_bytes[i], last: (i == n - 1),
                                         user: (i == n - 1) && f_user});
                end
                send_app_tx(n, f_user);
                check_byte("led", led, frame_bytes[0]);
            end else if (kind == "H") begin
                // start from an empty reply stage, then stall tx_hdr_ready
                limit += 200;
                do @(posedge clk); while (exp_hdr_q.size() != 0);
                hold_hdr = 1'b1;
            end else if (kind == "E") begin
                limit += 200;
                if (hold_hdr) begin
                    stop_with_error("second matching header was not held back by the pending reply");
                end
            end else begin
                stop_with_error($sformatf("unknown record kind %s in the golden file", kind));
            end
        end
        $fclose(fd);

        // drain everything still expected
        while (exp_hdr_q.size() != 0 || exp_app_q.size() != 0 || exp_tx_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* udp_echo.f */
+incdir+include
logic/udp_echo_pkg.sv
logic/udp_echo_cfg.sv
logic/udp_port_filter.sv
logic/udp_reply_hdr.sv
logic/udp_led_capture.sv
logic/udp_echo_top.sv
tb/udp_echo_tb.sv
